// File: hdl/mem_axi_pkg.sv
package mem_axi_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    //////////////////////////////////////////////////////////////////////
    // Client side request and response
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              we;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite channels
    //////////////////////////////////////////////////////////////////////

    // Response codes as carried on BRESP and RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
    } axi_r_t;

endpackage

// File: hdl/mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic                  clk,
    input  logic                  rst_n,

    // Client strobe interface
    input  logic                  req,
    input  mem_axi_pkg::mem_req_t req_data,
    output logic                  busy,
    output logic                  done,
    output mem_axi_pkg::mem_rsp_t rsp,

    // Towards the arbiter
    output logic                  pending,
    output mem_axi_pkg::mem_req_t slot,
    input  logic                  complete,
    input  mem_axi_pkg::mem_rsp_t result
);

    logic pending_q;
    logic done_q;
    logic accept;

    // A new request is only taken when the slot is fully free
    assign accept = req && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                pending_q <= 1'b1;
            end
            if (complete) begin
                pending_q <= 1'b0;
                done_q    <= 1'b1;
            end
        end
    end

    // Held request and returned response
    always_ff @(posedge clk) begin
        if (accept) begin
            slot <= req_data;
        end
        if (complete) begin
            rsp <= result;
        end
    end

    assign pending = pending_q;
    assign done    = done_q;
    // Busy stays up through the done cycle
    assign busy    = pending_q | done_q;

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int N_PORTS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Client slots
    input  logic [N_PORTS-1:0]    pending,
    input  mem_axi_pkg::mem_req_t slot [N_PORTS],
    output logic [N_PORTS-1:0]    complete,
    output mem_axi_pkg::mem_rsp_t result,

    // Bus master side
    output logic                  start,
    output mem_axi_pkg::mem_req_t cmd,
    input  logic                  finish,
    input  mem_axi_pkg::mem_rsp_t bus_result
);

    localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [IDX_W-1:0] owner_q;
    logic [IDX_W-1:0] pick;
    logic             found;
    logic             locked_q;

    // Round-robin search starting just after the last owner
    always_comb begin
        int cand;
        cand  = 0;
        pick  = owner_q;
        found = 1'b0;
        for (int i = 1; i <= N_PORTS; i++) begin
            cand = (int'(owner_q) + i) % N_PORTS;
            if (!found && pending[cand]) begin
                found = 1'b1;
                pick  = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked_q <= 1'b0;
            start    <= 1'b0;
            complete <= '0;
            // Port 0 wins the first round
            owner_q  <= IDX_W'(N_PORTS - 1);
        end else begin
            start    <= 1'b0;
            complete <= '0;
            if (!locked_q && found) begin
                locked_q <= 1'b1;
                start    <= 1'b1;
                owner_q  <= pick;
            end
            if (finish) begin
                complete[owner_q] <= 1'b1;
            end
            // Unlock once the owner has seen complete and dropped pending
            if (|complete) begin
                locked_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!locked_q && found) begin
            cmd <= slot[pick];
        end
        if (finish) begin
            result <= bus_result;
        end
    end

endmodule

// File: hdl/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
    input  logic                             clk,
    input  logic                             rst_n,

    // Command from the arbiter
    input  logic                             start,
    input  mem_axi_pkg::mem_req_t            cmd,
    output logic                             finish,
    output mem_axi_pkg::mem_rsp_t            result,

    // AW
    output logic                             awvalid,
    input  logic                             awready,
    output logic [mem_axi_pkg::ADDR_W-1:0]   awaddr,

    // W
    output logic                             wvalid,
    input  logic                             wready,
    output logic [mem_axi_pkg::DATA_W-1:0]   wdata,
    output logic [mem_axi_pkg::STRB_W-1:0]   wstrb,

    // B
    input  logic                             bvalid,
    output logic                             bready,
    input  logic [1:0]                       bresp,

    // AR
    output logic                             arvalid,
    input  logic                             arready,
    output logic [mem_axi_pkg::ADDR_W-1:0]   araddr,

    // R
    input  logic                             rvalid,
    output logic                             rready,
    input  logic [mem_axi_pkg::DATA_W-1:0]   rdata,
    input  logic [1:0]                       rresp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_WAIT_B,
        ST_READ,
        ST_WAIT_R
    } state_e;

    state_e               state_q;
    mem_axi_pkg::axi_aw_t aw_q;
    mem_axi_pkg::axi_w_t  w_q;
    mem_axi_pkg::axi_ar_t ar_q;
    mem_axi_pkg::axi_b_t  b_beat;
    mem_axi_pkg::axi_r_t  r_beat;
    logic                 aw_done;
    logic                 w_done;

    //////////////////////////////////////////////////////////////////////
    // Channel mapping
    //////////////////////////////////////////////////////////////////////

    assign awaddr = aw_q.addr;
    assign wdata  = w_q.data;
    assign wstrb  = w_q.strb;
    assign araddr = ar_q.addr;

    assign b_beat.resp = mem_axi_pkg::axi_resp_e'(bresp);
    assign r_beat.data = rdata;
    assign r_beat.resp = mem_axi_pkg::axi_resp_e'(rresp);

    // AW and W may be accepted in either order
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    //////////////////////////////////////////////////////////////////////
    // Transaction FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start && cmd.we) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state_q <= ST_WRITE;
                    end else if (start) begin
                        arvalid <= 1'b1;
                        state_q <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        bready  <= 1'b1;
                        state_q <= ST_WAIT_B;
                    end
                end
                ST_WAIT_B: begin
                    if (bvalid) begin
                        bready  <= 1'b0;
                        finish  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state_q <= ST_WAIT_R;
                    end
                end
                ST_WAIT_R: begin
                    if (rvalid) begin
                        rready  <= 1'b0;
                        finish  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Address, data and result capture
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start) begin
            aw_q.addr <= cmd.addr;
            ar_q.addr <= cmd.addr;
            w_q.data  <= cmd.wdata;
            w_q.strb  <= cmd.wstrb;
        end
        if (state_q == ST_WAIT_B && bvalid) begin
            result.rdata <= '0;
            result.err   <= (b_beat.resp != mem_axi_pkg::OKAY);
        end
        if (state_q == ST_WAIT_R && rvalid) begin
            result.rdata <= r_beat.data;
            result.err   <= (r_beat.resp != mem_axi_pkg::OKAY);
        end
    end

endmodule

// File: hdl/mem_axi_top.sv
`timescale 1ns/1ps

module mem_axi_top #(
    parameter int N_PORTS = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,

    // Instruction fetch client
    input  logic                             fetch_req,
    input  mem_axi_pkg::mem_req_t            fetch_req_data,
    output logic                             fetch_busy,
    output logic                             fetch_done,
    output mem_axi_pkg::mem_rsp_t            fetch_rsp,

    // Data client
    input  logic                             data_req,
    input  mem_axi_pkg::mem_req_t            data_req_data,
    output logic                             data_busy,
    output logic                             data_done,
    output mem_axi_pkg::mem_rsp_t            data_rsp,

    // AXI4-Lite master
    output logic                             m_axi_awvalid,
    input  logic                             m_axi_awready,
    output logic [mem_axi_pkg::ADDR_W-1:0]   m_axi_awaddr,
    output logic                             m_axi_wvalid,
    input  logic                             m_axi_wready,
    output logic [mem_axi_pkg::DATA_W-1:0]   m_axi_wdata,
    output logic [mem_axi_pkg::STRB_W-1:0]   m_axi_wstrb,
    input  logic                             m_axi_bvalid,
    output logic                             m_axi_bready,
    input  logic [1:0]                       m_axi_bresp,
    output logic                             m_axi_arvalid,
    input  logic                             m_axi_arready,
    output logic [mem_axi_pkg::ADDR_W-1:0]   m_axi_araddr,
    input  logic                             m_axi_rvalid,
    output logic                             m_axi_rready,
    input  logic [mem_axi_pkg::DATA_W-1:0]   m_axi_rdata,
    input  logic [1:0]                       m_axi_rresp
);

    // Port 0 is fetch, port 1 is data
    logic [N_PORTS-1:0]    pending;
    logic [N_PORTS-1:0]    complete;
    mem_axi_pkg::mem_req_t slot [N_PORTS];
    mem_axi_pkg::mem_rsp_t result;
    mem_axi_pkg::mem_req_t cmd;
    mem_axi_pkg::mem_rsp_t bus_result;
    logic                  start;
    logic                  finish;

    mem_port fetch_port_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (fetch_req),
        .req_data (fetch_req_data),
        .busy     (fetch_busy),
        .done     (fetch_done),
        .rsp      (fetch_rsp),
        .pending  (pending[0]),
        .slot     (slot[0]),
        .complete (complete[0]),
        .result   (result)
    );

    mem_port data_port_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (data_req),
        .req_data (data_req_data),
        .busy     (data_busy),
        .done     (data_done),
        .rsp      (data_rsp),
        .pending  (pending[1]),
        .slot     (slot[1]),
        .complete (complete[1]),
        .result   (result)
    );

    bus_arbiter #(
        .N_PORTS (N_PORTS)
    ) arb_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pending    (pending),
        .slot       (slot),
        .complete   (complete),
        .result     (result),
        .start      (start),
        .cmd        (cmd),
        .finish     (finish),
        .bus_result (bus_result)
    );

    axi_lite_master axi_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .cmd     (cmd),
        .finish  (finish),
        .result  (bus_result),
        .awvalid (m_axi_awvalid),
        .awready (m_axi_awready),
        .awaddr  (m_axi_awaddr),
        .wvalid  (m_axi_wvalid),
        .wready  (m_axi_wready),
        .wdata   (m_axi_wdata),
        .wstrb   (m_axi_wstrb),
        .bvalid  (m_axi_bvalid),
        .bready  (m_axi_bready),
        .bresp   (m_axi_bresp),
        .arvalid (m_axi_arvalid),
        .arready (m_axi_arready),
        .araddr  (m_axi_araddr),
        .rvalid  (m_axi_rvalid),
        .rready  (m_axi_rready),
        .rdata   (m_axi_rdata),
        .rresp   (m_axi_rresp)
    );

endmodule

// File: testbench/mem_axi_asserts.sv
`timescale 1ns/1ps

module mem_axi_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           fetch_req,
    input logic                           fetch_busy,
    input logic                           fetch_done,
    input logic                           data_req,
    input logic                           data_busy,
    input logic                           data_done,
    input logic                           m_axi_awvalid,
    input logic                           m_axi_awready,
    input logic [mem_axi_pkg::ADDR_W-1:0] m_axi_awaddr,
    input logic                           m_axi_wvalid,
    input logic                           m_axi_wready,
    input logic [mem_axi_pkg::DATA_W-1:0] m_axi_wdata,
    input logic [mem_axi_pkg::STRB_W-1:0] m_axi_wstrb,
    input logic                           m_axi_bready,
    input logic                           m_axi_arvalid,
    input logic                           m_axi_arready,
    input logic [mem_axi_pkg::ADDR_W-1:0] m_axi_araddr,
    input logic                           m_axi_rready
);

    logic       quiet;
    logic [7:0] fetch_wins;
    logic [7:0] data_wins;

    assign quiet = !(m_axi_awvalid || m_axi_wvalid || m_axi_arvalid || m_axi_bready
                     || m_axi_rready || fetch_busy || data_busy || fetch_done || data_done);

    // Completions of one port while the other one waits
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_wins <= 8'd0;
            data_wins  <= 8'd0;
        end else begin
            if (!data_busy) begin
                fetch_wins <= 8'd0;
            end else if (fetch_done) begin
                fetch_wins <= fetch_wins + 8'd1;
            end
            if (!fetch_busy) begin
                data_wins <= 8'd0;
            end else if (data_done) begin
                data_wins <= data_wins + 8'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reset and client strobes
    //////////////////////////////////////////////////////////////////////

    reset_quiet: assert property (@(posedge clk) !rst_n |=> quiet)
        else $error("bus or client strobes active during or right after reset");

    fetch_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req && !fetch_busy |=> fetch_busy)
        else $error("fetch request was not taken");

    data_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
        data_req && !data_busy |=> data_busy)
        else $error("data request was not taken");

    // Done only ends a request that was already open
    fetch_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done |-> $past(fetch_busy))
        else $error("fetch done without an open request");

    data_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        data_done |-> $past(data_busy))
        else $error("data done without an open request");

    //////////////////////////////////////////////////////////////////////
    // AXI valid/ready rules
    //////////////////////////////////////////////////////////////////////

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
        else $error("awvalid dropped or awaddr changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_wvalid && !m_axi_wready
        |=> m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb))
        else $error("wvalid dropped or write data changed before wready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
        else $error("arvalid dropped or araddr changed before arready");

    one_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(m_axi_arvalid && m_axi_awvalid))
        else $error("read and write address valid at the same time");

    // Round robin, at most one win while the other port waits
    fetch_fair: assert property (@(posedge clk) disable iff (!rst_n) fetch_wins <= 8'd1)
        else $error("fetch port completed twice while the data port waited");

    data_fair: assert property (@(posedge clk) disable iff (!rst_n) data_wins <= 8'd1)
        else $error("data port completed twice while the fetch port waited");

endmodule

bind mem_axi_top mem_axi_asserts asserts_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req     (fetch_req),
    .fetch_busy    (fetch_busy),
    .fetch_done    (fetch_done),
    .data_req      (data_req),
    .data_busy     (data_busy),
    .data_done     (data_done),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_bready  (m_axi_bready),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_rready  (m_axi_rready)
);

// File: testbench/mem_axi_tb.sv
`timescale 1ns/1ps

module mem_axi_tb;

    localparam int N_TRANS    = 200;
    // About 25 cycles per transaction with both ports contending
    localparam int MAX_CYCLES = N_TRANS * 2 * 25;

    logic clk   = 1'b0;
    logic rst_n = 1'b0;

    // Client side
    logic                  fetch_req      = 1'b0;
    mem_axi_pkg::mem_req_t fetch_req_data = '0;
    logic                  fetch_busy;
    logic                  fetch_done;
    mem_axi_pkg::mem_rsp_t fetch_rsp;
    logic                  data_req       = 1'b0;
    mem_axi_pkg::mem_req_t data_req_data  = '0;
    logic                  data_busy;
    logic                  data_done;
    mem_axi_pkg::mem_rsp_t data_rsp;

    // AXI4-Lite bus, slave model outputs
    logic        awvalid;
    logic        awready = 1'b0;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready  = 1'b0;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid  = 1'b0;
    logic        bready;
    logic [1:0]  bresp   = 2'b00;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] araddr;
    logic        rvalid  = 1'b0;
    logic        rready;
    logic [31:0] rdata   = '0;
    logic [1:0]  rresp   = 2'b00;

    integer      seed        = 32'hdb00_fa02;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] shadow    [256];
    logic [31:0] slave_mem [256];

    // Slave model state
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic [31:0] ar_addr_q;
    logic [1:0]  aw_cnt;
    logic [1:0]  w_cnt;
    logic [1:0]  b_cnt;
    logic [1:0]  ar_cnt;
    logic [1:0]  r_cnt;

    always #50 clk = ~clk;

    mem_axi_top #(
        .N_PORTS (2)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_req      (fetch_req),
        .fetch_req_data (fetch_req_data),
        .fetch_busy     (fetch_busy),
        .fetch_done     (fetch_done),
        .fetch_rsp      (fetch_rsp),
        .data_req       (data_req),
        .data_req_data  (data_req_data),
        .data_busy      (data_busy),
        .data_done      (data_done),
        .data_rsp       (data_rsp),
        .m_axi_awvalid  (awvalid),
        .m_axi_awready  (awready),
        .m_axi_awaddr   (awaddr),
        .m_axi_wvalid   (wvalid),
        .m_axi_wready   (wready),
        .m_axi_wdata    (wdata),
        .m_axi_wstrb    (wstrb),
        .m_axi_bvalid   (bvalid),
        .m_axi_bready   (bready),
        .m_axi_bresp    (bresp),
        .m_axi_arvalid  (arvalid),
        .m_axi_arready  (arready),
        .m_axi_araddr   (araddr),
        .m_axi_rvalid   (rvalid),
        .m_axi_rready   (rready),
        .m_axi_rdata    (rdata),
        .m_axi_rresp    (rresp)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic logic [1:0] rand_delay();
        logic [31:0] r;
        r = next_rand();
        return r[1:0];
    endfunction

    // Every byte depends on the full word index
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        fill_word = {idx, ~idx, idx ^ 8'ha5, idx + 8'h3c};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // One request on a client port, returns the response seen with done
    task automatic run_access(input logic use_data, input mem_axi_pkg::mem_req_t cmd,
                              output mem_axi_pkg::mem_rsp_t rsp);
        logic done_seen;
        done_seen = 1'b0;
        @(posedge clk);
        if (use_data) begin
            data_req      <= 1'b1;
            data_req_data <= cmd;
        end else begin
            fetch_req      <= 1'b1;
            fetch_req_data <= cmd;
        end
        @(posedge clk);
        if (use_data) begin
            data_req <= 1'b0;
        end else begin
            fetch_req <= 1'b0;
        end
        while (!done_seen) begin
            @(posedge clk);
            done_seen = use_data ? data_done : fetch_done;
        end
        rsp = use_data ? data_rsp : fetch_rsp;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Client drivers
    //////////////////////////////////////////////////////////////////////

    task automatic fetch_client();
        mem_axi_pkg::mem_req_t cmd;
        mem_axi_pkg::mem_rsp_t rsp;
        logic [31:0]           r;
        logic [7:0]            idx;
        for (int k = 0; k < N_TRANS; k++) begin
            r   = next_rand();
            // Upper half is never written
            idx = {1'b1, r[6:0]};
            cmd = '0;
            cmd.addr = {22'h0, idx, 2'b00};
            if (k % 16 == 5) begin
                cmd.addr[31] = 1'b1;
            end
            run_access(1'b0, cmd, rsp);
            check_value("fetch_rsp.err", 32'(cmd.addr[31]), 32'(rsp.err));
            if (!cmd.addr[31]) begin
                check_value("fetch_rsp.rdata", shadow[idx], rsp.rdata);
            end
        end
    endtask

    task automatic data_client();
        mem_axi_pkg::mem_req_t cmd;
        mem_axi_pkg::mem_rsp_t rsp;
        logic [31:0]           r;
        logic [7:0]            idx;
        for (int k = 0; k < N_TRANS / 2; k++) begin
            r   = next_rand();
            idx = {1'b0, r[6:0]};
            cmd = '0;
            cmd.addr = {22'h0, idx, 2'b00};
            if (k % 10 == 7) begin
                cmd.addr[31] = 1'b1;
            end
            cmd.wdata = next_rand();
            cmd.wstrb = r[11:8];
            cmd.we    = 1'b1;
            run_access(1'b1, cmd, rsp);
            check_value("data_rsp.err", 32'(cmd.addr[31]), 32'(rsp.err));
            check_value("data_rsp.rdata", 32'h0, rsp.rdata);
            if (!cmd.addr[31]) begin
                shadow[idx] = merge_bytes(shadow[idx], cmd.wdata, cmd.wstrb);
            end
            // Read back the same word
            cmd.we = 1'b0;
            run_access(1'b1, cmd, rsp);
            check_value("data_rsp.err", 32'(cmd.addr[31]), 32'(rsp.err));
            if (!cmd.addr[31]) begin
                check_value("data_rsp.rdata", shadow[idx], rsp.rdata);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite slave model with random stalls
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= 2'b00;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= 2'b00;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_cnt  <= 2'd0;
            w_cnt   <= 2'd0;
            b_cnt   <= 2'd0;
            ar_cnt  <= 2'd0;
            r_cnt   <= 2'd0;
            for (int i = 0; i < 256; i++) begin
                slave_mem[i] <= fill_word(8'(i));
            end
        end else begin
            // AW
            if (awvalid && awready) begin
                awready   <= 1'b0;
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
            end else if (awvalid) begin
                if (aw_cnt == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_cnt <= aw_cnt - 2'd1;
                end
            end else begin
                aw_cnt <= rand_delay();
            end
            // W
            if (wvalid && wready) begin
                wready   <= 1'b0;
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end else if (wvalid) begin
                if (w_cnt == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_cnt <= w_cnt - 2'd1;
                end
            end else begin
                w_cnt <= rand_delay();
            end
            // B once both address and data are in
            if (aw_got && w_got) begin
                if (b_cnt == 2'd0) begin
                    aw_got <= 1'b0;
                    w_got  <= 1'b0;
                    bvalid <= 1'b1;
                    if (aw_addr_q[31]) begin
                        bresp <= mem_axi_pkg::SLVERR;
                    end else begin
                        bresp <= mem_axi_pkg::OKAY;
                        slave_mem[aw_addr_q[9:2]] <=
                            merge_bytes(slave_mem[aw_addr_q[9:2]], w_data_q, w_strb_q);
                    end
                end else begin
                    b_cnt <= b_cnt - 2'd1;
                end
            end else begin
                b_cnt <= rand_delay();
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            // AR
            if (arvalid && arready) begin
                arready   <= 1'b0;
                ar_got    <= 1'b1;
                ar_addr_q <= araddr;
            end else if (arvalid) begin
                if (ar_cnt == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_cnt <= ar_cnt - 2'd1;
                end
            end else begin
                ar_cnt <= rand_delay();
            end
            // R
            if (ar_got) begin
                if (r_cnt == 2'd0) begin
                    ar_got <= 1'b0;
                    rvalid <= 1'b1;
                    rdata  <= slave_mem[ar_addr_q[9:2]];
                    rresp  <= ar_addr_q[31] ? mem_axi_pkg::SLVERR : mem_axi_pkg::OKAY;
                end else begin
                    r_cnt <= r_cnt - 2'd1;
                end
            end else begin
                r_cnt <= rand_delay();
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: transactions still open after %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(8'(i));
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fork
            fetch_client();
            data_client();
        join
        repeat (2) @(posedge clk);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: mem_axi_bridge.f
hdl/mem_axi_pkg.sv
hdl/mem_port.sv
hdl/bus_arbiter.sv
hdl/axi_lite_master.sv
hdl/mem_axi_top.sv
testbench/mem_axi_asserts.sv
testbench/mem_axi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then decide the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module mem_axi_tb -f mem_axi_bridge.f -o mem_axi_sim \
    && ./obj_dir/mem_axi_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "TEST RESULT: PASS" sim.log && ! grep -q "TEST RESULT: FAIL" sim.log \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
